// File: bm_cfg_pkg.sv
package bm_cfg_pkg;

    // --------------------
    // stream side
    // --------------------
    localparam int AXI_DW       = 32;   // read-data beat width

    // --------------------
    // feature map buffers
    // --------------------
    localparam int IFM_DW       = 32;
    localparam int IFM_AW       = 10;
    localparam int IFM_DEPTH    = 1 << IFM_AW;   // 1024 words

    // one row of the map, copied at channel sync
    localparam int ROW_AW       = 8;
    localparam int ROW_DEPTH    = 1 << ROW_AW;   // 256 words

    // --------------------
    // filter buffers
    // --------------------
    localparam int FILTER_DW    = 72;   // 3x3 kernel, one byte per tap
    localparam int FILTER_AW    = 6;
    localparam int FILTER_DEPTH = 1 << FILTER_AW;
    localparam int FILTER_BANKS = 4;    // one bank per beat byte

    // beats needed to fill one kernel word
    localparam int KERNEL_BEATS = 9;

    // --------------------
    // layer config
    // --------------------
    localparam int W_CHANNEL    = 4;

endpackage

// File: bm_types_pkg.sv
package bm_types_pkg;

    import bm_cfg_pkg::*;

    // one beat of the axi read-data stream, no back-pressure
    typedef struct packed {
        logic              vld;
        logic [AXI_DW-1:0] data;
    } axi_beat_t;

    // --------------------
    // read requests
    // --------------------
    typedef struct packed {
        logic              en;
        logic [IFM_AW-1:0] addr;
    } ifm_rd_t;   // tap port into the ifm buffer

    typedef struct packed {
        logic              en;
        logic [ROW_AW-1:0] addr;
    } row_rd_t;

    typedef struct packed {
        logic                 en;
        logic [FILTER_AW-1:0] addr;   // same address on every bank
    } fb_rd_t;

    // all banks side by side, bank 0 in the low word
    typedef logic [FILTER_BANKS-1:0][FILTER_DW-1:0] fb_data_t;

    // held stable for the whole layer
    typedef struct packed {
        logic [W_CHANNEL-1:0] q_channel;
        logic [ROW_AW-1:0]    q_row_stride;   // width * channel
    } layer_cfg_t;

    // row prefill FSM
    typedef enum logic [1:0] {
        PF_IDLE,
        PF_RUN,
        PF_DONE
    } pf_state_e;

endpackage

// File: dpram.sv
`timescale 1ns/1ps

// one write port, one read port with a registered output
module dpram #(
    parameter int DEPTH = 64,
    parameter int DW    = 32
) (
    input  logic                     clk,
    // write side
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [DW-1:0]            wdata,
    // read side
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [DW-1:0]            rdata
);

    logic [DW-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        if (re) begin
            rdata <= mem[raddr];   // old data on same-address collision
        end
    end

endmodule

// File: ifm_path.sv
`timescale 1ns/1ps

module ifm_path import bm_cfg_pkg::*, bm_types_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    input  axi_beat_t         axi_in,
    input  logic              load,
    input  layer_cfg_t        cfg,
    input  logic              csync_start,
    input  logic              csync_run,
    input  ifm_rd_t           tap,
    output logic [IFM_DW-1:0] tap_data,
    input  row_rd_t           row_rd,
    output logic [IFM_DW-1:0] row_data,
    output logic              pf_done
);

    // --------------------
    // stream -> ifm buffer
    // --------------------
    logic              load_d;
    logic              load_start;
    logic              wr_en;
    logic [IFM_AW-1:0] wr_addr;
    logic [IFM_DW-1:0] wr_data;

    assign load_start = load & ~load_d;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_d  <= 1'b0;
            wr_en   <= 1'b0;
            wr_addr <= '0;
        end else begin
            load_d <= load;
            wr_en  <= load & axi_in.vld;
            if (load_start) begin
                wr_addr <= '0;                  // every load starts at word 0
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= axi_in.data;
    end

    // --------------------
    // row prefill
    // --------------------
    pf_state_e         pf_state;
    logic [ROW_AW-1:0] pf_cnt;        // ifm read address during the run
    logic [ROW_AW-1:0] pf_last;
    logic              pf_rd;
    logic              pf_vld;        // read data arrives this cycle
    logic [ROW_AW-1:0] pf_waddr;

    assign pf_last = cfg.q_row_stride - 1'b1;
    assign pf_rd   = (pf_state == PF_RUN);
    assign pf_done = (pf_state == PF_DONE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pf_state <= PF_IDLE;
            pf_cnt   <= '0;
        end else if (csync_start) begin
            pf_state <= PF_RUN;
            pf_cnt   <= '0;
        end else if (!csync_run) begin
            pf_state <= PF_IDLE;              // controller dropped the sync
        end else begin
            case (pf_state)
                PF_RUN: begin
                    pf_cnt <= pf_cnt + 1'b1;
                    if (pf_cnt == pf_last) begin
                        pf_state <= PF_DONE;
                    end
                end
                default: ;                    // idle and done wait for start or run low
            endcase
        end
    end

    // write side trails the read by the ram latency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pf_vld   <= 1'b0;
            pf_waddr <= '0;
        end else begin
            pf_vld   <= pf_rd;
            pf_waddr <= pf_cnt;
        end
    end

    // --------------------
    // ifm buffer, read port shared by tap and prefill
    // --------------------
    logic              ifm_re;
    logic [IFM_AW-1:0] ifm_raddr;
    logic [IFM_DW-1:0] ifm_rdata;

    assign ifm_re    = tap.en | pf_rd;
    assign ifm_raddr = tap.en ? tap.addr : {{(IFM_AW-ROW_AW){1'b0}}, pf_cnt};   // tap wins
    assign tap_data  = ifm_rdata;

    dpram #(
        .DEPTH (IFM_DEPTH),
        .DW    (IFM_DW)
    ) ifm_buf_i (
        .clk   (clk),
        .we    (wr_en),
        .waddr (wr_addr),
        .wdata (wr_data),
        .re    (ifm_re),
        .raddr (ifm_raddr),
        .rdata (ifm_rdata)
    );

    dpram #(
        .DEPTH (ROW_DEPTH),
        .DW    (IFM_DW)
    ) row_buf_i (
        .clk   (clk),
        .we    (pf_vld),
        .waddr (pf_waddr),
        .wdata (ifm_rdata),
        .re    (row_rd.en),
        .raddr (row_rd.addr),
        .rdata (row_data)
    );

endmodule

// File: filter_path.sv
`timescale 1ns/1ps

module filter_path import bm_cfg_pkg::*, bm_types_pkg::*; (
    input  logic                 clk,
    input  logic                 rstn,
    input  axi_beat_t            axi_in,
    input  logic                 load,
    input  logic [W_CHANNEL-1:0] channel,
    input  logic                 csync_start,
    input  fb_rd_t               fb_rd,
    output fb_data_t             fb_data,
    output logic                 fb_ready
);

    // --------------------
    // arm on load edge
    // --------------------
    logic load_d;
    logic armed;
    logic in_vld;
    logic f_start;   // first beat of a new load

    assign in_vld  = load & axi_in.vld;
    assign f_start = armed & in_vld;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_d <= 1'b0;
            armed  <= 1'b0;
        end else begin
            load_d <= load;
            if (load & ~load_d) begin
                armed <= 1'b1;
            end else if (f_start) begin
                armed <= 1'b0;
            end
        end
    end

    // --------------------
    // kernel packer
    // --------------------
    logic [$clog2(KERNEL_BEATS)-1:0] kpos;
    logic [$clog2(KERNEL_BEATS)-1:0] kpos_use;
    logic                            kcommit;
    logic                            kcommit_d;   // bank write strobe
    logic [FILTER_AW-1:0]            wr_addr;
    logic [FILTER_AW-1:0]            last_addr;
    fb_data_t                        acc;

    assign kpos_use  = f_start ? '0 : kpos;
    assign kcommit   = in_vld && (kpos_use == KERNEL_BEATS - 1);
    assign last_addr = {channel, 2'b00} - 1'b1;   // 4 words per channel

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kpos      <= '0;
            kcommit_d <= 1'b0;
            wr_addr   <= '0;
        end else begin
            kcommit_d <= kcommit;
            if (in_vld) begin
                kpos <= kcommit ? '0 : kpos_use + 1'b1;
            end
            if (kcommit_d) begin
                wr_addr <= (wr_addr == last_addr) ? '0 : wr_addr + 1'b1;
            end
            if (f_start) begin
                wr_addr <= '0;   // new load restarts at word 0
            end
        end
    end

    // byte b of the beat lands in lane kpos of bank b
    always_ff @(posedge clk) begin
        if (in_vld) begin
            for (int b = 0; b < FILTER_BANKS; b++) begin
                acc[b][8*kpos_use +: 8] <= axi_in.data[8*b +: 8];
            end
        end
    end

    // --------------------
    // filter complete flag
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fb_ready <= 1'b0;
        end else if (csync_start) begin
            fb_ready <= 1'b0;
        end else if (kcommit_d && (wr_addr == last_addr)) begin
            fb_ready <= 1'b1;   // last word of the layer going in
        end
    end

    // --------------------
    // banks
    // --------------------
    for (genvar b = 0; b < FILTER_BANKS; b++) begin : g_bank
        dpram #(
            .DEPTH (FILTER_DEPTH),
            .DW    (FILTER_DW)
        ) bank_i (
            .clk   (clk),
            .we    (kcommit_d),
            .waddr (wr_addr),
            .wdata (acc[b]),
            .re    (fb_rd.en),
            .raddr (fb_rd.addr),
            .rdata (fb_data[b])
        );
    end

endmodule

// File: csync_ctrl.sv
`timescale 1ns/1ps

module csync_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic csync_run,
    input  logic fb_ready,
    input  logic pf_done,
    output logic csync_start,
    output logic csync_done
);

    logic run_d;

    // start pulse lands one cycle after run rises
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_d       <= 1'b0;
            csync_start <= 1'b0;
        end else begin
            run_d       <= csync_run;
            csync_start <= csync_run & ~run_d;
        end
    end

    // both paths complete while the controller still holds run
    assign csync_done = csync_run & fb_ready & pf_done;

endmodule

// File: buffer_manager.sv
`timescale 1ns/1ps

module buffer_manager import bm_cfg_pkg::*, bm_types_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // stream and load control
    input  axi_beat_t         axi_in,
    input  logic              q_load_ifm,
    input  logic              q_load_filter,
    input  layer_cfg_t        cfg,
    input  logic              c_csync_run,
    // read ports
    input  ifm_rd_t           tap,
    output logic [IFM_DW-1:0] tap_data,
    input  row_rd_t           row_rd,
    output logic [IFM_DW-1:0] row_data,
    input  fb_rd_t            fb_rd,
    output fb_data_t          fb_data,
    // status
    output logic              fb_ready,
    output logic              csync_done
);

    logic csync_start;
    logic pf_done;

    ifm_path ifm_path_i (
        .clk         (clk),
        .rstn        (rstn),
        .axi_in      (axi_in),
        .load        (q_load_ifm),
        .cfg         (cfg),
        .csync_start (csync_start),
        .csync_run   (c_csync_run),
        .tap         (tap),
        .tap_data    (tap_data),
        .row_rd      (row_rd),
        .row_data    (row_data),
        .pf_done     (pf_done)
    );

    filter_path filter_path_i (
        .clk         (clk),
        .rstn        (rstn),
        .axi_in      (axi_in),
        .load        (q_load_filter),
        .channel     (cfg.q_channel),
        .csync_start (csync_start),
        .fb_rd       (fb_rd),
        .fb_data     (fb_data),
        .fb_ready    (fb_ready)
    );

    csync_ctrl csync_ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .csync_run   (c_csync_run),
        .fb_ready    (fb_ready),
        .pf_done     (pf_done),
        .csync_start (csync_start),
        .csync_done  (csync_done)
    );

endmodule

// File: bm_props.sv
`timescale 1ns/1ps

module bm_props (
    input logic clk,
    input logic rstn,
    input logic c_csync_run,
    input logic csync_start,
    input logic fb_ready,
    input logic csync_done
);

    // done needs run and filters and never shows in the start cycle
    done_qualified: assert property (@(posedge clk) disable iff (!rstn)
        csync_done |-> (fb_ready && c_csync_run && !csync_start))
        else $error("csync_done high without fb_ready and c_csync_run or during csync_start");

    ready_cleared: assert property (@(posedge clk) disable iff (!rstn)
        csync_start |=> !fb_ready)
        else $error("fb_ready still high the cycle after csync_start");

    controls_known: assert property (@(posedge clk) disable iff (!rstn)
        !$isunknown({fb_ready, csync_done, csync_start}))
        else $error("control output unknown out of reset");

endmodule

bind buffer_manager bm_props props_i (
    .clk         (clk),
    .rstn        (rstn),
    .c_csync_run (c_csync_run),
    .csync_start (csync_start),
    .fb_ready    (fb_ready),
    .csync_done  (csync_done)
);

// File: bm_tests.svh
`ifndef BM_TESTS_SVH
`define BM_TESTS_SVH

// --------------------
// stream drivers
// --------------------
// n beats into the ifm buffer from word 0, random idle cycles in between
task automatic send_ifm(input int n);
    logic [31:0] r;
    @(posedge clk);
    q_load_ifm <= 1'b1;
    for (int i = 0; i < n; i++) begin
        rand_bits(1, r);
        if (r[0]) begin
            @(posedge clk);
            axi_in <= '0;                   // valid low this cycle
        end
        rand_bits(AXI_DW, r);
        ifm_model[i] = r;
        @(posedge clk);
        axi_in <= '{vld: 1'b1, data: r};
    end
    @(posedge clk);
    axi_in     <= '0;
    q_load_ifm <= 1'b0;
    repeat (2) @(posedge clk);
endtask

task automatic start_filter_load();
    logic [31:0] r;
    for (int i = 0; i < FB_BEATS; i++) begin
        rand_bits(AXI_DW, r);
        fbeats[i] = r;
    end
    @(posedge clk);
    q_load_filter <= 1'b1;
    repeat (2) @(posedge clk);             // packer arms after the load edge
endtask

task automatic stream_filter(input int first, input int last);
    for (int i = first; i <= last; i++) begin
        @(posedge clk);
        axi_in <= '{vld: 1'b1, data: fbeats[i]};
    end
    @(posedge clk);
    axi_in <= '0;
endtask

// bank b lane k of word n is byte b of beat 9n+k
task automatic verify_banks();
    fb_data_t exp;
    fb_data_t got;
    for (int n = 0; n < FB_WORDS; n++) begin
        for (int b = 0; b < FILTER_BANKS; b++) begin
            for (int k = 0; k < KERNEL_BEATS; k++) begin
                exp[b][8*k +: 8] = fbeats[KERNEL_BEATS*n + k][8*b +: 8];
            end
        end
        read_fb(n, got);
        check_filter($sformatf("fb_data[%0d]", n), got, exp);
    end
endtask

task automatic wait_done(input int limit);
    int cyc;
    cyc = 0;
    @(negedge clk);
    while (csync_done !== 1'b1) begin
        if (cyc >= limit) begin
            abort_run($sformatf("csync_done did not rise within %0d cycles", limit));
        end
        cyc++;
        @(negedge clk);
    end
endtask

// --------------------
// directed tests
// --------------------
task automatic ifm_load_and_tap();
    logic [IFM_DW-1:0] d;
    send_ifm(64);
    for (int a = 0; a < 64; a++) begin
        read_tap(a, d);
        check_word($sformatf("tap_data[%0d]", a), d, ifm_model[a]);
    end
endtask

task automatic ifm_reload();
    logic [IFM_DW-1:0] d;
    send_ifm(8);                            // model keeps words 8 onward
    for (int a = 0; a < 64; a++) begin
        read_tap(a, d);
        check_word($sformatf("tap_data[%0d]", a), d, ifm_model[a]);
    end
endtask

task automatic filter_packing();
    start_filter_load();
    stream_filter(0, FB_BEATS - 2);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("fb_ready", fb_ready, 1'b0);
    stream_filter(FB_BEATS - 1, FB_BEATS - 1);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_flag("fb_ready", fb_ready, 1'b1);
    @(posedge clk);
    q_load_filter <= 1'b0;
    verify_banks();
endtask

// last filter beat lands after csync_start so fb_ready survives the start
task automatic prefill_and_sync();
    logic [IFM_DW-1:0] d;
    start_filter_load();
    stream_filter(0, FB_BEATS - 2);
    @(posedge clk);
    c_csync_run <= 1'b1;
    fork
        begin
            repeat (2) @(posedge clk);
            stream_filter(FB_BEATS - 1, FB_BEATS - 1);
        end
        wait_done(cfg.q_row_stride + 4);
    join
    @(posedge clk);
    q_load_filter <= 1'b0;
    repeat (2) @(posedge clk);
    for (int a = 0; a < cfg.q_row_stride; a++) begin
        read_row(a, d);
        check_word($sformatf("row_data[%0d]", a), d, ifm_model[a]);
    end
endtask

task automatic done_needs_filter();
    @(posedge clk);
    c_csync_run <= 1'b0;
    repeat (3) @(posedge clk);
    c_csync_run <= 1'b1;                    // new sync clears fb_ready
    repeat (40) begin
        @(negedge clk);
        check_flag("csync_done", csync_done, 1'b0);
    end
    check_flag("fb_ready", fb_ready, 1'b0);
    start_filter_load();
    stream_filter(0, FB_BEATS - 1);
    wait_done(8);
    @(posedge clk);
    q_load_filter <= 1'b0;
    verify_banks();
    @(posedge clk);
    c_csync_run <= 1'b0;
    repeat (2) @(posedge clk);
endtask

`endif

// File: tb_buffer_manager.sv
`timescale 1ns/1ps

module tb_buffer_manager
    import bm_cfg_pkg::*, bm_types_pkg::*;
();

    localparam int CLK_NS   = 8;
    localparam int FB_WORDS = 8;                       // q_channel 2, four words each
    localparam int FB_BEATS = KERNEL_BEATS * FB_WORDS;

    // cycle budget, one term per test plus reset
    localparam int RUN_CYCLES = 20
                              + (2*64 + 2*64 + 8)
                              + (2*8 + 2*64 + 8)
                              + (FB_BEATS + 2*FB_WORDS + 16)
                              + (FB_BEATS + 2*16 + 32)
                              + (40 + FB_BEATS + 2*FB_WORDS + 32);
    localparam int WATCHDOG_NS = RUN_CYCLES * CLK_NS + 1000;

    logic              clk;
    logic              rstn;
    axi_beat_t         axi_in;
    logic              q_load_ifm;
    logic              q_load_filter;
    layer_cfg_t        cfg;
    logic              c_csync_run;
    ifm_rd_t           tap;
    logic [IFM_DW-1:0] tap_data;
    row_rd_t           row_rd;
    logic [IFM_DW-1:0] row_data;
    fb_rd_t            fb_rd;
    fb_data_t          fb_data;
    logic              fb_ready;
    logic              csync_done;

    logic [31:0]       lfsr_state;
    logic [IFM_DW-1:0] ifm_model [64];        // expected ifm words 0..63
    logic [AXI_DW-1:0] fbeats [FB_BEATS];     // beats of the latest filter load

    buffer_manager dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .axi_in        (axi_in),
        .q_load_ifm    (q_load_ifm),
        .q_load_filter (q_load_filter),
        .cfg           (cfg),
        .c_csync_run   (c_csync_run),
        .tap           (tap),
        .tap_data      (tap_data),
        .row_rd        (row_rd),
        .row_data      (row_data),
        .fb_rd         (fb_rd),
        .fb_data       (fb_data),
        .fb_ready      (fb_ready),
        .csync_done    (csync_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS/2) clk = ~clk;
    end

    // --------------------
    // random data
    // --------------------
    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            val = {val[30:0], lfsr_state[0]};   // one step per bit
        end
    endtask

    // --------------------
    // checks
    // --------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string name, input logic [IFM_DW-1:0] got,
                              input logic [IFM_DW-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_filter(input string name, input fb_data_t got, input fb_data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s got 0x%h exp 0x%h", name, got, exp));
        end
    endtask

    // --------------------
    // read ports, data one cycle after the request
    // --------------------
    task automatic read_tap(input int addr, output logic [IFM_DW-1:0] data);
        @(posedge clk);
        tap <= '{en: 1'b1, addr: IFM_AW'(addr)};
        @(posedge clk);
        tap <= '0;
        @(negedge clk);
        data = tap_data;
    endtask

    task automatic read_row(input int addr, output logic [IFM_DW-1:0] data);
        @(posedge clk);
        row_rd <= '{en: 1'b1, addr: ROW_AW'(addr)};
        @(posedge clk);
        row_rd <= '0;
        @(negedge clk);
        data = row_data;
    endtask

    task automatic read_fb(input int addr, output fb_data_t data);
        @(posedge clk);
        fb_rd <= '{en: 1'b1, addr: FILTER_AW'(addr)};
        @(posedge clk);
        fb_rd <= '0;
        @(negedge clk);
        data = fb_data;
    endtask

    `include "bm_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        lfsr_state    = 32'd80;
        rstn          = 1'b0;
        axi_in        = '0;
        q_load_ifm    = 1'b0;
        q_load_filter = 1'b0;
        cfg           = '{q_channel: 4'd2, q_row_stride: 8'd16};
        c_csync_run   = 1'b0;
        tap           = '0;
        row_rd        = '0;
        fb_rd         = '0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        repeat (4) @(posedge clk);
        ifm_load_and_tap();
        ifm_reload();
        filter_packing();
        prefill_and_sync();
        done_needs_filter();
        $display("test passed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
bm_cfg_pkg.sv
bm_types_pkg.sv
dpram.sv
ifm_path.sv
filter_path.sv
csync_ctrl.sv
buffer_manager.sv
bm_props.sv
tb_buffer_manager.sv

// File: Bender.yml
package:
  name: buffer_manager

sources:
  - files:
      - bm_cfg_pkg.sv
      - bm_types_pkg.sv
      - dpram.sv
      - ifm_path.sv
      - filter_path.sv
      - csync_ctrl.sv
      - buffer_manager.sv
  - target: test
    include_dirs:
      - .
    files:
      - bm_props.sv
      - tb_buffer_manager.sv
